// File: rtl/gb_timing_cfg.svh
`ifndef GB_TIMING_CFG_SVH
`define GB_TIMING_CFG_SVH

// Divider shared by the timer, the frame sequencer and the DIV register
`define GB_DIV_WIDTH 16

// 512 Hz tap at a 4,194,304 Hz master clock
`define GB_FS_TAP 12

// Divider bits for TAC clock selects 0 to 3
`define GB_TAC_TAP0 9
`define GB_TAC_TAP1 3
`define GB_TAC_TAP2 5
`define GB_TAC_TAP3 7

// Low address bytes of the FF04 to FF07 register block
`define GB_ADDR_DIV  8'h04
`define GB_ADDR_TIMA 8'h05
`define GB_ADDR_TMA  8'h06
`define GB_ADDR_TAC  8'h07

`endif

// File: rtl/gb_timing_pkg.sv
`include "gb_timing_cfg.svh"

package gb_timing_pkg;

	typedef logic [7:0] byte_t;

	// Low byte of an FFxx I/O address
	typedef logic [7:0] io_addr_t;

	typedef logic [`GB_DIV_WIDTH-1:0] div_t;

	typedef logic [2:0] fs_step_t;

	// CPU request, held steady by the CPU until it transfers on m_tick
	typedef struct packed {
		io_addr_t addr;
		logic     we;
		byte_t    wdata;
	} bus_req_t;

	// Write strobes fan out to the divider and the timer with one data byte
	typedef struct packed {
		logic  div_wr;
		logic  tima_wr;
		logic  tma_wr;
		logic  tac_wr;
		byte_t data;
	} reg_wr_t;

	typedef struct packed {
		byte_t      tima;
		byte_t      tma;
		logic [2:0] tac;
	} timer_regs_t;

	// Tick pulses are one cycle wide and come with the step they decode from
	typedef struct packed {
		logic     length_tick;
		logic     sweep_tick;
		logic     envelope_tick;
		fs_step_t step;
	} apu_ticks_t;

endpackage

// File: rtl/div_counter.sv
`timescale 1ns/10ps
`default_nettype none

module div_counter (
	input  logic                   clkin_a,
	input  logic                   rst,
	input  gb_timing_pkg::reg_wr_t reg_wr,
	output gb_timing_pkg::div_t    div,
	output logic                   m_tick,
	output logic                   phi_out
);

	gb_timing_pkg::div_t div_q;

	// Any write to DIV clears the whole divider, not just the visible byte
	always_ff @(posedge clkin_a) begin
		if (rst || reg_wr.div_wr) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	assign div = div_q;

	// Last T-cycle of each machine cycle, where the CPU side may transfer
	assign m_tick = div_q[1] & div_q[0];

	// CPU phase clock at 1 MHz
	assign phi_out = div_q[1];

endmodule

`default_nettype wire

// File: rtl/tima_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "gb_timing_cfg.svh"

module tima_timer (
	input  logic                       clkin_a,
	input  logic                       rst,
	input  gb_timing_pkg::reg_wr_t     reg_wr,
	input  gb_timing_pkg::div_t        div,
	output gb_timing_pkg::timer_regs_t timer_regs,
	output logic                       timer_irq
);

	gb_timing_pkg::byte_t tima;
	gb_timing_pkg::byte_t tma;
	logic [2:0]           tac;
	logic                 tap_sel;
	logic                 timer_in;
	logic                 timer_in_q;
	logic                 tima_inc;

	always_comb begin
		case (tac[1:0])
			2'd0:    tap_sel = div[`GB_TAC_TAP0];
			2'd1:    tap_sel = div[`GB_TAC_TAP1];
			2'd2:    tap_sel = div[`GB_TAC_TAP2];
			default: tap_sel = div[`GB_TAC_TAP3];
		endcase
	end

	// The enable is ANDed in before edge detection, so clearing TAC bit 2
	// while the tap is high also counts once, as on the real chip
	assign timer_in = tac[2] & tap_sel;
	assign tima_inc = timer_in_q & ~timer_in;

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			timer_in_q <= 1'b0;
		end else begin
			timer_in_q <= timer_in;
		end
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			tima      <= '0;
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= 1'b0;
			if (reg_wr.tima_wr) begin
				tima <= reg_wr.data;
			end else if (tima_inc) begin
				if (tima == 8'hff) begin
					// Reload happens at the overflow edge itself
					tima      <= tma;
					timer_irq <= 1'b1;
				end else begin
					tima <= tima + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			tma <= '0;
			tac <= '0;
		end else begin
			if (reg_wr.tma_wr) begin
				tma <= reg_wr.data;
			end
			if (reg_wr.tac_wr) begin
				tac <= reg_wr.data[2:0];
			end
		end
	end

	assign timer_regs.tima = tima;
	assign timer_regs.tma  = tma;
	assign timer_regs.tac  = tac;

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "gb_timing_cfg.svh"

module frame_sequencer (
	input  logic                      clkin_a,
	input  logic                      rst,
	input  logic                      apu_enable,
	input  gb_timing_pkg::div_t       div,
	output gb_timing_pkg::apu_ticks_t apu_ticks
);

	gb_timing_pkg::fs_step_t step;
	gb_timing_pkg::fs_step_t next_step;
	logic                    fs_tap_q;
	logic                    fs_fall;
	logic                    length_tick;
	logic                    sweep_tick;
	logic                    envelope_tick;

	assign fs_fall   = fs_tap_q & ~div[`GB_FS_TAP];
	assign next_step = step + 1'b1;

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			fs_tap_q <= 1'b0;
		end else begin
			fs_tap_q <= div[`GB_FS_TAP];
		end
	end

	// Step and ticks update together so a tick always matches the new step
	always_ff @(posedge clkin_a) begin
		if (rst) begin
			step          <= '0;
			length_tick   <= 1'b0;
			sweep_tick    <= 1'b0;
			envelope_tick <= 1'b0;
		end else begin
			length_tick   <= 1'b0;
			sweep_tick    <= 1'b0;
			envelope_tick <= 1'b0;
			if (!apu_enable) begin
				step <= '0;
			end else if (fs_fall) begin
				step          <= next_step;
				length_tick   <= ~next_step[0];
				sweep_tick    <= (next_step[1:0] == 2'b10);
				envelope_tick <= (next_step == 3'd7);
			end
		end
	end

	assign apu_ticks.length_tick   = length_tick;
	assign apu_ticks.sweep_tick    = sweep_tick;
	assign apu_ticks.envelope_tick = envelope_tick;
	assign apu_ticks.step          = step;

endmodule

`default_nettype wire

// File: rtl/timing_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "gb_timing_cfg.svh"

module timing_regs (
	input  logic                       clkin_a,
	input  logic                       rst,
	input  logic                       bus_valid,
	input  gb_timing_pkg::bus_req_t    bus_req,
	output logic                       bus_ready,
	output logic                       rsp_valid,
	output gb_timing_pkg::byte_t       rsp_data,
	input  logic                       m_tick,
	input  gb_timing_pkg::div_t        div,
	input  gb_timing_pkg::timer_regs_t timer_regs,
	output gb_timing_pkg::reg_wr_t     reg_wr
);

	logic                 xfer;
	logic                 wr_xfer;
	logic                 rd_xfer;
	gb_timing_pkg::byte_t rd_data;

	// Accesses only land on the machine-cycle boundary
	assign bus_ready = m_tick;
	assign xfer      = bus_valid & m_tick;
	assign wr_xfer   = xfer & bus_req.we;
	assign rd_xfer   = xfer & ~bus_req.we;

	assign reg_wr.div_wr  = wr_xfer & (bus_req.addr == `GB_ADDR_DIV);
	assign reg_wr.tima_wr = wr_xfer & (bus_req.addr == `GB_ADDR_TIMA);
	assign reg_wr.tma_wr  = wr_xfer & (bus_req.addr == `GB_ADDR_TMA);
	assign reg_wr.tac_wr  = wr_xfer & (bus_req.addr == `GB_ADDR_TAC);
	assign reg_wr.data    = bus_req.wdata;

	always_comb begin
		case (bus_req.addr)
			`GB_ADDR_DIV:  rd_data = div[`GB_DIV_WIDTH-1 -: 8];
			`GB_ADDR_TIMA: rd_data = timer_regs.tima;
			`GB_ADDR_TMA:  rd_data = timer_regs.tma;
			// Unused TAC bits float high on the data bus
			`GB_ADDR_TAC:  rd_data = {5'b11111, timer_regs.tac};
			default:       rd_data = 8'hff;
		endcase
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= rd_xfer;
		end
	end

	always_ff @(posedge clkin_a) begin
		if (rd_xfer) begin
			rsp_data <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: rtl/gb_timing_top.sv
`timescale 1ns/10ps
`default_nettype none

module gb_timing_top (
	input  logic                      clkin_a,
	input  logic                      rst,
	input  logic                      apu_enable,
	input  logic                      bus_valid,
	input  gb_timing_pkg::bus_req_t   bus_req,
	output logic                      bus_ready,
	output logic                      rsp_valid,
	output gb_timing_pkg::byte_t      rsp_data,
	output logic                      phi_out,
	output logic                      timer_irq,
	output gb_timing_pkg::apu_ticks_t apu_ticks
);

	gb_timing_pkg::div_t        div;
	gb_timing_pkg::reg_wr_t     reg_wr;
	gb_timing_pkg::timer_regs_t timer_regs;
	logic                       m_tick;

	div_counter u_div (
		.clkin_a (clkin_a),
		.rst     (rst),
		.reg_wr  (reg_wr),
		.div     (div),
		.m_tick  (m_tick),
		.phi_out (phi_out)
	);

	tima_timer u_timer (
		.clkin_a    (clkin_a),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.div        (div),
		.timer_regs (timer_regs),
		.timer_irq  (timer_irq)
	);

	frame_sequencer u_fs (
		.clkin_a    (clkin_a),
		.rst        (rst),
		.apu_enable (apu_enable),
		.div        (div),
		.apu_ticks  (apu_ticks)
	);

	timing_regs u_regs (
		.clkin_a    (clkin_a),
		.rst        (rst),
		.bus_valid  (bus_valid),
		.bus_req    (bus_req),
		.bus_ready  (bus_ready),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.m_tick     (m_tick),
		.div        (div),
		.timer_regs (timer_regs),
		.reg_wr     (reg_wr)
	);

endmodule

`default_nettype wire

// File: sim/tb_gb_timing.sv
`timescale 1ns/10ps

`include "gb_timing_cfg.svh"

module tb_gb_timing;

	localparam int FS_WINDOW = 65536;
	localparam int RATE_SPAN = 8 * (1024 + 256 + 64 + 16) + 4096;
	localparam int WATCHDOG_CYCLES = 4 * (2 * FS_WINDOW + RATE_SPAN + 8192);

	logic                      clkin_a;
	logic                      rst;
	logic                      apu_enable;
	logic                      bus_valid;
	gb_timing_pkg::bus_req_t   bus_req;
	logic                      bus_ready;
	logic                      rsp_valid;
	gb_timing_pkg::byte_t      rsp_data;
	logic                      phi_out;
	logic                      timer_irq;
	gb_timing_pkg::apu_ticks_t apu_ticks;

	int unsigned model_cnt = 0;
	int unsigned cyc = 0;
	logic        model_tick;
	logic        model_fs_q;
	logic        model_fall;
	int          seed = 34005;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	string       test_name = "reset";
	int          irq_count = 0;
	int unsigned irq_at = 0;
	logic        fs_arm = 1'b0;
	logic [2:0]  ticks;
	int          tick_count [3];
	int unsigned tick_last [3];

	gb_timing_top u_dut (
		.clkin_a    (clkin_a),
		.rst        (rst),
		.apu_enable (apu_enable),
		.bus_valid  (bus_valid),
		.bus_req    (bus_req),
		.bus_ready  (bus_ready),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.phi_out    (phi_out),
		.timer_irq  (timer_irq),
		.apu_ticks  (apu_ticks)
	);

	initial begin
		clkin_a = 1'b0;
		forever #5 clkin_a = ~clkin_a;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clkin_a);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	// Reference divider, a cycle count since reset or the last DIV write
	assign model_tick = (model_cnt % 4) == 3;
	always @(posedge clkin_a) begin
		cyc <= cyc + 1;
		if (rst || (bus_valid && model_tick && bus_req.we && bus_req.addr == `GB_ADDR_DIV)) begin
			model_cnt <= 0;
		end else begin
			model_cnt <= model_cnt + 1;
		end
	end

	// Falling edge of the 512 Hz tap in the reference count
	assign model_fall = model_fs_q & ~model_cnt[`GB_FS_TAP];
	always @(posedge clkin_a) begin
		if (rst) begin
			model_fs_q <= 1'b0;
		end else begin
			model_fs_q <= model_cnt[`GB_FS_TAP];
		end
	end

	always @(posedge clkin_a) begin
		if (timer_irq) begin
			irq_count <= irq_count + 1;
			irq_at <= model_cnt;
		end
	end

	// Length, sweep and envelope ticks repeat every 16384 << i cycles
	assign ticks = {apu_ticks.envelope_tick, apu_ticks.sweep_tick, apu_ticks.length_tick};
	always @(posedge clkin_a) begin
		for (int i = 0; i < 3; i++) begin
			if (fs_arm && ticks[i]) begin
				if (tick_count[i] > 0) begin
					assert (cyc - tick_last[i] == (16384 << i))
						else report_mismatch("tick_gap", 16384 << i, cyc - tick_last[i]);
				end
				tick_count[i] <= tick_count[i] + 1;
				tick_last[i] <= cyc;
			end
		end
	end

	a_ready: assert property (@(posedge clkin_a) disable iff (rst) bus_ready == model_tick)
		else report_mismatch("bus_ready", $sampled(model_tick), $sampled(bus_ready));
	a_rsp: assert property (@(posedge clkin_a) disable iff (rst)
		rsp_valid == $past(bus_valid && bus_ready && !bus_req.we))
		else report_mismatch("rsp_valid", !$sampled(rsp_valid), $sampled(rsp_valid));
	a_phi: assert property (@(posedge clkin_a) disable iff (rst) phi_out == model_cnt[1])
		else report_mismatch("phi_out", $sampled(model_cnt[1]), $sampled(phi_out));
	a_irq: assert property (@(posedge clkin_a) disable iff (rst) timer_irq |=> !timer_irq)
		else report_mismatch("timer_irq_width", 0, 1);
	a_quiet: assert property (@(posedge clkin_a) disable iff (rst)
		!apu_enable |=> (ticks == 3'b000 && apu_ticks.step == 0))
		else report_mismatch("apu_quiet", 0, $sampled({ticks, apu_ticks.step}));
	// The step moves by one in the cycle after each tap fall and holds otherwise
	a_step: assert property (@(posedge clkin_a) disable iff (rst)
		apu_enable |=> apu_ticks.step == 3'($past(apu_ticks.step) + $past(model_fall)))
		else report_mismatch("fs_step", 3'($past(apu_ticks.step) + $past(model_fall)),
			$sampled(apu_ticks.step));

	task automatic report_mismatch(input string what, input int exp, input int act);
		errors++;
		test_errors++;
		$display("CHECK FAILED %s/%s expected %0h actual %0h", test_name, what, exp, act);
	endtask

	task automatic expect_equal(input string what, input int exp, input int act);
		assert (exp == act) else report_mismatch(what, exp, act);
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clkin_a);
	endtask

	// Holds the request until bus_ready, then collects the read response
	task automatic bus_access(input gb_timing_pkg::io_addr_t addr, input logic we,
			input gb_timing_pkg::byte_t wdata, output gb_timing_pkg::byte_t rdata,
			output int unsigned xfer_cnt);
		int waited;
		waited = 0;
		rdata = 8'hxx;
		@(posedge clkin_a);
		bus_valid <= 1'b1;
		bus_req <= {addr, we, wdata};
		do begin
			@(posedge clkin_a);
			waited++;
		end while (!bus_ready && waited < 8);
		xfer_cnt = model_cnt;
		bus_valid <= 1'b0;
		if (!bus_ready) begin
			errors++;
			test_errors++;
			$display("%s: bus_ready did not come within 8 cycles", test_name);
		end else if (!we) begin
			@(posedge clkin_a);
			rdata = rsp_data;
		end
	endtask

	task automatic write_reg(input gb_timing_pkg::io_addr_t addr, input gb_timing_pkg::byte_t d);
		gb_timing_pkg::byte_t unused;
		int unsigned cnt;
		bus_access(addr, 1'b1, d, unused, cnt);
	endtask

	task automatic read_reg(input gb_timing_pkg::io_addr_t addr,
			output gb_timing_pkg::byte_t d, output int unsigned cnt);
		bus_access(addr, 1'b0, 8'h00, d, cnt);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors > 0) begin
			tests_failed++;
		end
		$display("test %s: %0d failed checks", test_name, test_errors);
	endtask

	task automatic count_ticks(output int counts [3]);
		for (int i = 0; i < 3; i++) begin
			tick_count[i] = 0;
		end
		@(posedge clkin_a);
		fs_arm <= 1'b1;
		idle(FS_WINDOW);
		fs_arm <= 1'b0;
		idle(1);
		counts = tick_count;
	endtask

	initial begin
		gb_timing_pkg::byte_t d;
		gb_timing_pkg::byte_t t1;
		gb_timing_pkg::byte_t t2;
		gb_timing_pkg::byte_t diff;
		gb_timing_pkg::byte_t tma_val;
		int unsigned c1;
		int unsigned c2;
		int unsigned cw;
		int unsigned period;
		int irq_before;
		int waited;
		int counts [3];
		rst = 1'b1;
		apu_enable = 1'b1;
		bus_valid = 1'b0;
		bus_req = '0;
		repeat (10) @(posedge clkin_a);
		rst <= 1'b0;
		idle(4);

		start_test("bus_handshake");
		read_reg(8'h40, d, c1);
		expect_equal("unmapped", 8'hff, d);
		d = $random(seed);
		write_reg(`GB_ADDR_TAC, d & 8'hfb);
		read_reg(`GB_ADDR_TAC, t1, c1);
		expect_equal("tac", {5'b11111, d[2:0] & 3'b011}, t1);
		tma_val = $random(seed);
		write_reg(`GB_ADDR_TMA, tma_val);
		read_reg(`GB_ADDR_TMA, t1, c1);
		expect_equal("tma", tma_val, t1);
		end_test();

		start_test("divider");
		idle(1000);
		read_reg(`GB_ADDR_DIV, d, c1);
		expect_equal("div", (c1 >> 8) & 255, d);
		write_reg(`GB_ADDR_DIV, $random(seed));
		idle(700);
		read_reg(`GB_ADDR_DIV, d, c1);
		expect_equal("div_restart", (c1 >> 8) & 255, d);
		end_test();

		// TMA of zero makes an overflow look like a plain wrap
		start_test("timer_rates");
		write_reg(`GB_ADDR_TMA, 8'h00);
		for (int sel = 0; sel < 4; sel++) begin
			period = (sel == 0) ? 1024 : (16 << (2 * (sel - 1)));
			write_reg(`GB_ADDR_TAC, 4 + sel);
			read_reg(`GB_ADDR_TIMA, t1, c1);
			idle(8 * period);
			read_reg(`GB_ADDR_TIMA, t2, c2);
			diff = t2 - t1;
			expect_equal($sformatf("rate_sel%0d", sel), (c2 / period - c1 / period) & 255, diff);
		end
		write_reg(`GB_ADDR_TAC, 8'h03);
		read_reg(`GB_ADDR_TIMA, t1, c1);
		idle(4096);
		read_reg(`GB_ADDR_TIMA, t2, c2);
		expect_equal("disabled", t1, t2);
		end_test();

		start_test("overflow");
		tma_val = $random(seed);
		write_reg(`GB_ADDR_TMA, tma_val);
		write_reg(`GB_ADDR_TAC, 8'h04);
		irq_before = irq_count;
		write_reg(`GB_ADDR_TIMA, 8'hff);
		waited = 0;
		while (irq_count == irq_before && waited < 2048) begin
			@(posedge clkin_a);
			waited++;
		end
		if (irq_count == irq_before) begin
			errors++;
			test_errors++;
			$display("%s: timer_irq never pulsed after the TIMA overflow", test_name);
		end
		read_reg(`GB_ADDR_TIMA, t1, c1);
		expect_equal("reload", tma_val, t1);
		expect_equal("irq_phase", 1, irq_at % 1024);
		idle(64);
		expect_equal("irq_count", irq_before + 1, irq_count);
		end_test();

		// The DIV write lands at count 11, where divider bit 3 is high
		start_test("div_clear_quirk");
		write_reg(`GB_ADDR_TAC, 8'h05);
		read_reg(`GB_ADDR_TIMA, t1, c1);
		while (model_cnt % 16 != 8) begin
			@(posedge clkin_a);
		end
		bus_access(`GB_ADDR_DIV, 1'b1, 8'h00, d, cw);
		idle(40);
		read_reg(`GB_ADDR_TIMA, t2, c2);
		diff = t2 - t1;
		expect_equal("quirk", (cw / 16 - c1 / 16 + 1 + c2 / 16) & 255, diff);
		end_test();

		start_test("frame_sequencer");
		count_ticks(counts);
		for (int i = 0; i < 3; i++) begin
			expect_equal($sformatf("ticks%0d", i), FS_WINDOW >> (14 + i), counts[i]);
		end
		apu_enable <= 1'b0;
		idle(2);
		count_ticks(counts);
		for (int i = 0; i < 3; i++) begin
			expect_equal($sformatf("quiet%0d", i), 0, counts[i]);
		end
		end_test();

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+rtl
rtl/gb_timing_pkg.sv
rtl/div_counter.sv
rtl/tima_timer.sv
rtl/frame_sequencer.sv
rtl/timing_regs.sv
rtl/gb_timing_top.sv
sim/tb_gb_timing.sv
